//--- rtl/id_pkg.sv
package id_pkg;

    localparam int NUM_REGS = 32;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP_SPECIAL   = 6'h00;
    localparam logic [5:0] OP_LU12I     = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_MEM       = 6'h0a;
    localparam logic [5:0] OP_JIRL      = 6'h13;
    localparam logic [5:0] OP_B         = 6'h14;
    localparam logic [5:0] OP_BL        = 6'h15;
    localparam logic [5:0] OP_BEQ       = 6'h16;
    localparam logic [5:0] OP_BNE       = 6'h17;
    localparam logic [5:0] OP_BLT       = 6'h18;
    localparam logic [5:0] OP_BGE       = 6'h19;
    localparam logic [5:0] OP_BLTU      = 6'h1a;
    localparam logic [5:0] OP_BGEU      = 6'h1b;

    // inst[25:22] under OP_SPECIAL and OP_MEM
    localparam logic [3:0] OP2_REG    = 4'h0;
    localparam logic [3:0] OP2_SHIFTI = 4'h1;
    localparam logic [3:0] OP2_SLTI   = 4'h8;
    localparam logic [3:0] OP2_SLTUI  = 4'h9;
    localparam logic [3:0] OP2_ADDI   = 4'ha;
    localparam logic [3:0] OP2_ANDI   = 4'hd;
    localparam logic [3:0] OP2_ORI    = 4'he;
    localparam logic [3:0] OP2_XORI   = 4'hf;
    localparam logic [3:0] OP2_LD_W   = 4'h2;
    localparam logic [3:0] OP2_ST_W   = 4'h6;

    // inst[21:15], 3R and shift-immediate forms
    localparam logic [6:0] FN_ADD_W  = 7'h20;
    localparam logic [6:0] FN_SUB_W  = 7'h22;
    localparam logic [6:0] FN_SLT    = 7'h24;
    localparam logic [6:0] FN_SLTU   = 7'h25;
    localparam logic [6:0] FN_NOR    = 7'h28;
    localparam logic [6:0] FN_AND    = 7'h29;
    localparam logic [6:0] FN_OR     = 7'h2a;
    localparam logic [6:0] FN_XOR    = 7'h2b;
    localparam logic [6:0] FN_SLL_W  = 7'h2e;
    localparam logic [6:0] FN_SRL_W  = 7'h2f;
    localparam logic [6:0] FN_SRA_W  = 7'h30;
    localparam logic [6:0] FN_SLLI_W = 7'h01;
    localparam logic [6:0] FN_SRLI_W = 7'h09;
    localparam logic [6:0] FN_SRAI_W = 7'h11;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_UI5, IMM_SI12, IMM_UI12, IMM_SI20, IMM_FOUR
    } imm_kind_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B_BL, BR_JIRL
    } branch_kind_e;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic      res_from_mem;
        rf_write_t wr;
    } es_fwd_t;

    typedef struct packed {
        alu_op_e      alu_op;
        imm_kind_e    imm_kind;
        logic [31:0]  imm;
        logic         src1_is_pc;
        logic         src2_is_imm;
        logic         src2_is_rd;
        logic         rf_we;
        logic [4:0]   dest;
        logic         res_from_mem;
        logic         mem_we;
        branch_kind_e br_kind;
        logic [31:0]  br_offs;
        logic         need_r1;
        logic         need_r2;
    } decode_t;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        res_from_mem;
        logic [31:0] alu_src1;
        logic [31:0] alu_src2;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rkd_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic [4:0]        raddr1,
    input  logic [4:0]        raddr2,
    output logic [31:0]       rdata1,
    output logic [31:0]       rdata2,
    input  id_pkg::rf_write_t wr
);
    import id_pkg::*;

    logic [31:0] regs [NUM_REGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != 5'd0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]     inst,
    output id_pkg::decode_t dec
);
    import id_pkg::*;

    logic [5:0]  op;
    logic [3:0]  op2;
    logic [6:0]  fn;
    logic [4:0]  rd;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    assign op  = inst[31:26];
    assign op2 = inst[25:22];
    assign fn  = inst[21:15];
    assign rd  = inst[4:0];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        // anything not matched below stays a bubble
        dec.alu_op       = ALU_NONE;
        dec.imm_kind     = IMM_NONE;
        dec.src1_is_pc   = 1'b0;
        dec.src2_is_rd   = 1'b0;
        dec.rf_we        = 1'b0;
        dec.res_from_mem = 1'b0;
        dec.mem_we       = 1'b0;
        dec.br_kind      = BR_NONE;
        dec.need_r1      = 1'b0;
        dec.need_r2      = 1'b0;

        case (op)
            OP_SPECIAL: begin
                case (op2)
                    OP2_REG: begin
                        case (fn)
                            FN_ADD_W: dec.alu_op = ALU_ADD;
                            FN_SUB_W: dec.alu_op = ALU_SUB;
                            FN_SLT:   dec.alu_op = ALU_SLT;
                            FN_SLTU:  dec.alu_op = ALU_SLTU;
                            FN_NOR:   dec.alu_op = ALU_NOR;
                            FN_AND:   dec.alu_op = ALU_AND;
                            FN_OR:    dec.alu_op = ALU_OR;
                            FN_XOR:   dec.alu_op = ALU_XOR;
                            FN_SLL_W: dec.alu_op = ALU_SLL;
                            FN_SRL_W: dec.alu_op = ALU_SRL;
                            FN_SRA_W: dec.alu_op = ALU_SRA;
                            default:  dec.alu_op = ALU_NONE;
                        endcase
                    end
                    OP2_SHIFTI: begin
                        dec.imm_kind = IMM_UI5;
                        case (fn)
                            FN_SLLI_W: dec.alu_op = ALU_SLL;
                            FN_SRLI_W: dec.alu_op = ALU_SRL;
                            FN_SRAI_W: dec.alu_op = ALU_SRA;
                            default:   dec.alu_op = ALU_NONE;
                        endcase
                    end
                    OP2_SLTI: begin
                        dec.alu_op   = ALU_SLT;
                        dec.imm_kind = IMM_SI12;
                    end
                    OP2_SLTUI: begin
                        dec.alu_op   = ALU_SLTU;
                        dec.imm_kind = IMM_SI12;
                    end
                    OP2_ADDI: begin
                        dec.alu_op   = ALU_ADD;
                        dec.imm_kind = IMM_SI12;
                    end
                    OP2_ANDI: begin
                        dec.alu_op   = ALU_AND;
                        dec.imm_kind = IMM_UI12;
                    end
                    OP2_ORI: begin
                        dec.alu_op   = ALU_OR;
                        dec.imm_kind = IMM_UI12;
                    end
                    OP2_XORI: begin
                        dec.alu_op   = ALU_XOR;
                        dec.imm_kind = IMM_UI12;
                    end
                    default: dec.alu_op = ALU_NONE;
                endcase
                dec.rf_we   = (dec.alu_op != ALU_NONE);
                dec.need_r1 = dec.rf_we;
                dec.need_r2 = dec.rf_we && (dec.imm_kind == IMM_NONE);
            end
            OP_LU12I: begin
                if (!inst[25]) begin
                    dec.alu_op   = ALU_LUI;
                    dec.imm_kind = IMM_SI20;
                    dec.rf_we    = 1'b1;
                end
            end
            OP_PCADDU12I: begin
                if (!inst[25]) begin
                    dec.alu_op     = ALU_ADD;
                    dec.imm_kind   = IMM_SI20;
                    dec.src1_is_pc = 1'b1;
                    dec.rf_we      = 1'b1;
                end
            end
            OP_MEM: begin
                if (op2 == OP2_LD_W) begin
                    dec.alu_op       = ALU_ADD;
                    dec.imm_kind     = IMM_SI12;
                    dec.rf_we        = 1'b1;
                    dec.res_from_mem = 1'b1;
                    dec.need_r1      = 1'b1;
                end else if (op2 == OP2_ST_W) begin
                    // store data comes from rd on the second read port
                    dec.alu_op     = ALU_ADD;
                    dec.imm_kind   = IMM_SI12;
                    dec.mem_we     = 1'b1;
                    dec.src2_is_rd = 1'b1;
                    dec.need_r1    = 1'b1;
                    dec.need_r2    = 1'b1;
                end
            end
            OP_JIRL, OP_BL: begin
                // link value is pc + 4
                dec.alu_op     = ALU_ADD;
                dec.imm_kind   = IMM_FOUR;
                dec.src1_is_pc = 1'b1;
                dec.rf_we      = 1'b1;
                dec.br_kind    = (op == OP_JIRL) ? BR_JIRL : BR_B_BL;
                dec.need_r1    = (op == OP_JIRL);
            end
            OP_B: dec.br_kind = BR_B_BL;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                dec.src2_is_rd = 1'b1;
                dec.need_r1    = 1'b1;
                dec.need_r2    = 1'b1;
                case (op)
                    OP_BEQ:  dec.br_kind = BR_BEQ;
                    OP_BNE:  dec.br_kind = BR_BNE;
                    OP_BLT:  dec.br_kind = BR_BLT;
                    OP_BGE:  dec.br_kind = BR_BGE;
                    OP_BLTU: dec.br_kind = BR_BLTU;
                    default: dec.br_kind = BR_BGEU;
                endcase
            end
            default: dec.alu_op = ALU_NONE;
        endcase

        dec.src2_is_imm = (dec.imm_kind != IMM_NONE);
        dec.dest        = (op == OP_BL) ? 5'd1 : rd;

        case (dec.imm_kind)
            IMM_UI5:  dec.imm = {27'd0, rk};
            IMM_SI12: dec.imm = {{20{i12[11]}}, i12};
            IMM_UI12: dec.imm = {20'd0, i12};
            IMM_SI20: dec.imm = {i20, 12'd0};
            IMM_FOUR: dec.imm = 32'd4;
            default:  dec.imm = 32'd0;
        endcase

        // word offsets, shifted by two
        case (dec.br_kind)
            BR_NONE: dec.br_offs = 32'd0;
            BR_B_BL: dec.br_offs = {{4{i26[25]}}, i26, 2'b00};
            default: dec.br_offs = {{14{i16[15]}}, i16, 2'b00};
        endcase
    end

endmodule

//--- rtl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  id_pkg::decode_t   dec,
    input  logic [31:0]       inst,
    input  logic [31:0]       rf_rdata1,
    input  logic [31:0]       rf_rdata2,
    output logic [4:0]        rf_raddr1,
    output logic [4:0]        rf_raddr2,
    input  id_pkg::es_fwd_t   es_fwd,
    input  id_pkg::rf_write_t ms_fwd,
    input  id_pkg::rf_write_t ws_fwd,
    output logic [31:0]       rj_value,
    output logic [31:0]       rkd_value,
    output logic              load_use
);
    import id_pkg::*;

    logic es_hit1;
    logic es_hit2;

    function automatic logic hits(input logic [4:0] addr, input rf_write_t w);
        return w.we && (addr != 5'd0) && (w.waddr == addr);
    endfunction

    // youngest writer wins
    function automatic logic [31:0] pick(
        input logic [4:0]  addr,
        input logic [31:0] rf_data,
        input rf_write_t   es,
        input rf_write_t   ms,
        input rf_write_t   ws
    );
        if (hits(addr, es)) return es.wdata;
        if (hits(addr, ms)) return ms.wdata;
        if (hits(addr, ws)) return ws.wdata;
        return rf_data;
    endfunction

    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = dec.src2_is_rd ? inst[4:0] : inst[14:10];

    assign rj_value  = pick(rf_raddr1, rf_rdata1, es_fwd.wr, ms_fwd, ws_fwd);
    assign rkd_value = pick(rf_raddr2, rf_rdata2, es_fwd.wr, ms_fwd, ws_fwd);

    // load data is not ready until memory stage
    assign es_hit1  = hits(rf_raddr1, es_fwd.wr);
    assign es_hit2  = hits(rf_raddr2, es_fwd.wr);
    assign load_use = es_fwd.res_from_mem &&
                      ((es_hit1 && dec.need_r1) || (es_hit2 && dec.need_r2));

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::decode_t dec,
    input  logic [31:0]     pc,
    input  logic [31:0]     rj_value,
    input  logic [31:0]     rkd_value,
    output logic            taken,
    output logic [31:0]     target
);
    import id_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    always_comb begin
        case (dec.br_kind)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_B_BL, BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = (dec.br_kind == BR_JIRL) ? rj_value + dec.br_offs : pc + dec.br_offs;

endmodule

//--- rtl/id_control.sv
`timescale 1ns/1ps

module id_control (
    input  logic              clk,
    input  logic              resetn,
    input  logic              fs_valid,
    input  id_pkg::fs_to_ds_t fs_to_ds,
    input  logic              es_allowin,
    input  logic              load_use,
    input  logic              branch_taken,
    output logic              ds_allowin,
    output logic              ds_to_es_valid,
    output id_pkg::fs_to_ds_t ds_cur,
    output logic              br_fire
);

    logic ds_valid;
    logic ds_ready_go;

    assign ds_ready_go    = !load_use;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign br_fire        = ds_to_es_valid && es_allowin && branch_taken;

    // a taken branch squashes whatever fetch offers on the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_fire) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin && !br_fire) begin
            ds_cur <= fs_to_ds;
        end
    end

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              fs_valid,
    input  id_pkg::fs_to_ds_t fs_to_ds,
    output logic              ds_allowin,
    output logic              ds_to_es_valid,
    output id_pkg::ds_to_es_t ds_to_es,
    input  logic              es_allowin,
    output id_pkg::br_t       br,
    input  id_pkg::es_fwd_t   es_fwd,
    input  id_pkg::rf_write_t ms_fwd,
    input  id_pkg::rf_write_t ws_fwd
);
    import id_pkg::*;

    fs_to_ds_t   ds_cur;
    decode_t     dec;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        load_use;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        br_fire;

    id_control u_control (
        .clk            (clk),
        .resetn         (resetn),
        .fs_valid       (fs_valid),
        .fs_to_ds       (fs_to_ds),
        .es_allowin     (es_allowin),
        .load_use       (load_use),
        .branch_taken   (branch_taken),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_cur         (ds_cur),
        .br_fire        (br_fire)
    );

    inst_decoder u_decoder (
        .inst (ds_cur.inst),
        .dec  (dec)
    );

    // writeback port doubles as the register file write
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_fwd)
    );

    operand_forward u_forward (
        .dec       (dec),
        .inst      (ds_cur.inst),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .load_use  (load_use)
    );

    branch_unit u_branch (
        .dec       (dec),
        .pc        (ds_cur.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .taken     (branch_taken),
        .target    (branch_target)
    );

    assign ds_to_es.alu_op       = dec.alu_op;
    assign ds_to_es.res_from_mem = dec.res_from_mem;
    assign ds_to_es.alu_src1     = dec.src1_is_pc ? ds_cur.pc : rj_value;
    assign ds_to_es.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
    assign ds_to_es.mem_we       = dec.mem_we;
    assign ds_to_es.rf_we        = dec.rf_we;
    assign ds_to_es.rf_waddr     = dec.dest;
    assign ds_to_es.rkd_value    = rkd_value;
    assign ds_to_es.pc           = ds_cur.pc;

    assign br.taken  = br_fire;
    assign br.target = branch_target;

endmodule

//--- test/id_stage_assertions.sv
`timescale 1ns/1ps

module id_stage_assertions (
    input logic              clk,
    input logic              resetn,
    input logic              load_use,
    input logic              ds_allowin,
    input logic              ds_to_es_valid,
    input logic              es_allowin,
    input id_pkg::ds_to_es_t ds_to_es,
    input id_pkg::br_t       br
);
    import id_pkg::*;

    // a stalled item stays in the stage
    stall_holds_item: assert property (
        @(posedge clk) disable iff (!resetn)
        (load_use && !ds_allowin) |=> $stable(ds_to_es.pc)
    ) else $error("stalled item changed during a load-use hazard");

    // held item does not move while execute refuses it
    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!resetn)
        (ds_to_es_valid && !es_allowin) |=> $stable(ds_to_es)
    ) else $error("ds_to_es changed under back-pressure");

    // a redirect empties the stage
    redirect_empties_stage: assert property (
        @(posedge clk) disable iff (!resetn)
        br.taken |=> !ds_to_es_valid
    ) else $error("stage still valid after a redirect");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk            (clk),
    .resetn         (resetn),
    .load_use       (load_use),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allowin     (es_allowin),
    .ds_to_es       (ds_to_es),
    .br             (br)
);

//--- test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        resetn;
    logic        fs_valid;
    fs_to_ds_t   fs_to_ds;
    logic        ds_allowin;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es;
    logic        es_allowin;
    br_t         br;
    es_fwd_t     es_fwd;
    rf_write_t   ms_fwd;
    rf_write_t   ws_fwd;
    int          cycles = 0;
    logic [31:0] model [NUM_REGS];

    id_stage id_stage_inst (
        .clk            (clk),
        .resetn         (resetn),
        .fs_valid       (fs_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .br             (br),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "timeout after %0d cycles, the DUT stopped making progress", cycles);
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] enc_3r(input logic [6:0] fn, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {OP_SPECIAL, OP2_REG, fn, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [5:0] op, input logic [3:0] op2,
                                              input logic [11:0] imm, input logic [4:0] rj,
                                              input logic [4:0] rd);
        return {op, op2, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shifti(input logic [6:0] fn, input logic [4:0] ui5,
                                               input logic [4:0] rj, input logic [4:0] rd);
        return {OP_SPECIAL, OP2_SHIFTI, fn, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [5:0] op, input logic [19:0] imm,
                                              input logic [4:0] rd);
        return {op, 1'b0, imm, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [15:0] offs,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    // 26-bit offset is split, low half in [25:10]
    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom;
        return 5'd1 + 5'(r % 31);
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    // preload through the writeback port
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        ws_fwd = '{1'b1, addr, data};
        @(negedge clk);
        ws_fwd.we = 1'b0;
        if (addr != 5'd0) begin
            model[addr] = data;
        end
    endtask

    // fetch offers an item, returns once the stage takes it on the next rising edge
    task automatic offer(input logic [31:0] inst, input logic [31:0] pc);
        @(negedge clk);
        fs_valid = 1'b1;
        fs_to_ds = '{inst, pc};
        #1;
        while (!ds_allowin) begin
            @(negedge clk);
            #1;
        end
    endtask

    // returns with the item held in the stage, just after a falling edge
    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        offer(inst, pc);
        @(negedge clk);
        fs_valid = 1'b0;
        #1;
    endtask

    task automatic test_alu_reg();
        logic [6:0] fns [11] = '{FN_ADD_W, FN_SUB_W, FN_SLT, FN_SLTU, FN_NOR, FN_AND,
                                 FN_OR, FN_XOR, FN_SLL_W, FN_SRL_W, FN_SRA_W};
        alu_op_e ops [11] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
                              ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
        logic [4:0] rj;
        logic [4:0] rk;
        logic [4:0] rd;
        logic [31:0] pc;
        for (int i = 0; i < 11; i++) begin
            rj = rand_reg();
            rk = rand_reg();
            rd = rand_reg();
            pc = rand_pc();
            write_reg(rj, $urandom);
            write_reg(rk, $urandom);
            issue(enc_3r(fns[i], rk, rj, rd), pc);
            check("ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
            check("alu_op", 32'(ds_to_es.alu_op), 32'(ops[i]));
            check("alu_src1", ds_to_es.alu_src1, model[rj]);
            check("alu_src2", ds_to_es.alu_src2, model[rk]);
            check("rf_we", 32'(ds_to_es.rf_we), 32'd1);
            check("rf_waddr", 32'(ds_to_es.rf_waddr), 32'(rd));
            check("pc", ds_to_es.pc, pc);
        end
    endtask

    task automatic test_imm_decode();
        logic [31:0] pc;
        pc = rand_pc();
        write_reg(5'd10, $urandom);
        write_reg(5'd12, $urandom);
        issue(enc_2ri12(OP_SPECIAL, OP2_ADDI, 12'h8f0, 5'd10, 5'd11), pc);
        check("addi alu_op", 32'(ds_to_es.alu_op), 32'(ALU_ADD));
        check("addi alu_src1", ds_to_es.alu_src1, model[10]);
        check("addi alu_src2", ds_to_es.alu_src2, 32'hffff_f8f0);
        issue(enc_2ri12(OP_SPECIAL, OP2_ANDI, 12'h8f0, 5'd10, 5'd11), pc);
        check("andi alu_op", 32'(ds_to_es.alu_op), 32'(ALU_AND));
        check("andi alu_src2", ds_to_es.alu_src2, 32'h0000_08f0);
        issue(enc_shifti(FN_SLLI_W, 5'd13, 5'd10, 5'd11), pc);
        check("slli alu_op", 32'(ds_to_es.alu_op), 32'(ALU_SLL));
        check("slli alu_src2", ds_to_es.alu_src2, 32'd13);
        issue(enc_1ri20(OP_LU12I, 20'h81234, 5'd11), pc);
        check("lu12i alu_op", 32'(ds_to_es.alu_op), 32'(ALU_LUI));
        check("lu12i alu_src2", ds_to_es.alu_src2, 32'h8123_4000);
        check("lu12i rf_waddr", 32'(ds_to_es.rf_waddr), 32'd11);
        issue(enc_1ri20(OP_PCADDU12I, 20'h00012, 5'd11), pc);
        check("pcaddu12i alu_src1", ds_to_es.alu_src1, pc);
        check("pcaddu12i alu_src2", ds_to_es.alu_src2, 32'h0001_2000);
        issue(enc_2ri12(OP_MEM, OP2_ST_W, 12'h010, 5'd10, 5'd12), pc);
        check("st mem_we", 32'(ds_to_es.mem_we), 32'd1);
        check("st rf_we", 32'(ds_to_es.rf_we), 32'd0);
        check("st rkd_value", ds_to_es.rkd_value, model[12]);
        check("st alu_src2", ds_to_es.alu_src2, 32'd16);
        issue(enc_2ri12(OP_MEM, OP2_LD_W, 12'hffc, 5'd10, 5'd13), pc);
        check("ld res_from_mem", 32'(ds_to_es.res_from_mem), 32'd1);
        check("ld rf_we", 32'(ds_to_es.rf_we), 32'd1);
        check("ld alu_src2", ds_to_es.alu_src2, 32'hffff_fffc);
    endtask

    task automatic test_forwarding();
        logic [31:0] inst;
        inst = enc_3r(FN_ADD_W, 5'd4, 5'd3, 5'd5);
        write_reg(5'd3, 32'h3333_0000);
        write_reg(5'd4, 32'h4444_0000);
        @(negedge clk);
        es_fwd = '{1'b0, '{1'b1, 5'd3, 32'haaaa_0001}};
        ms_fwd = '{1'b1, 5'd3, 32'hbbbb_0002};
        ws_fwd = '{1'b1, 5'd3, 32'hcccc_0003};
        issue(inst, rand_pc());
        check("fwd execute", ds_to_es.alu_src1, 32'haaaa_0001);
        check("fwd untouched rk", ds_to_es.alu_src2, model[4]);
        @(negedge clk);
        es_fwd.wr.we = 1'b0;
        issue(inst, rand_pc());
        check("fwd memory", ds_to_es.alu_src1, 32'hbbbb_0002);
        @(negedge clk);
        ms_fwd.we = 1'b0;
        offer(inst, rand_pc());
        // new writeback data, not yet in the register file
        @(negedge clk);
        fs_valid = 1'b0;
        ws_fwd.wdata = 32'hcccc_0004;
        #1;
        check("fwd writeback", ds_to_es.alu_src1, 32'hcccc_0004);
        model[3] = 32'hcccc_0004;
        @(negedge clk);
        es_fwd = '{1'b0, '{1'b1, 5'd0, 32'h1111_1111}};
        ms_fwd = '{1'b1, 5'd0, 32'h2222_2222};
        ws_fwd = '{1'b1, 5'd0, 32'h5555_5555};
        issue(enc_3r(FN_ADD_W, 5'd4, 5'd0, 5'd5), rand_pc());
        check("r0 alu_src1", ds_to_es.alu_src1, 32'd0);
        @(negedge clk);
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
    endtask

    task automatic test_load_use();
        write_reg(5'd6, 32'h0606_0606);
        @(negedge clk);
        es_fwd = '{1'b1, '{1'b1, 5'd6, 32'hdead_0006}};
        issue(enc_3r(FN_ADD_W, 5'd4, 5'd6, 5'd7), rand_pc());
        for (int i = 0; i < 4; i++) begin
            check("stall ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
            check("stall ds_allowin", 32'(ds_allowin), 32'd0);
            @(negedge clk);
            #1;
        end
        // load has moved on to memory
        @(negedge clk);
        es_fwd = '0;
        ms_fwd = '{1'b1, 5'd6, 32'h1234_5678};
        #1;
        check("release ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
        check("release alu_src1", ds_to_es.alu_src1, 32'h1234_5678);
        check("release alu_src2", ds_to_es.alu_src2, model[4]);
        @(negedge clk);
        ms_fwd = '0;
        #1;
        check("after leave ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
    endtask

    task automatic test_branches();
        logic [5:0] ops [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [15:0] o16;
        logic [25:0] o26;
        logic        taken;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = $urandom;
                b = $urandom;
                if (k == 0) b = a;
                if (k == 1) b = a ^ 32'h8000_0000;
                write_reg(5'd7, a);
                write_reg(5'd8, b);
                o16 = 16'($urandom);
                pc = rand_pc();
                case (i)
                    0: taken = (a == b);
                    1: taken = (a != b);
                    2: taken = ($signed(a) < $signed(b));
                    3: taken = ($signed(a) >= $signed(b));
                    4: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                issue(enc_2ri16(ops[i], o16, 5'd7, 5'd8), pc);
                check("br.taken", 32'(br.taken), 32'(taken));
                check("branch rf_we", 32'(ds_to_es.rf_we), 32'd0);
                if (taken) begin
                    check("br.target", br.target, pc + {{14{o16[15]}}, o16, 2'b00});
                end
            end
        end
        a = $urandom;
        write_reg(5'd9, a);
        o16 = 16'($urandom);
        pc = rand_pc();
        issue(enc_2ri16(OP_JIRL, o16, 5'd9, 5'd20), pc);
        check("jirl br.taken", 32'(br.taken), 32'd1);
        check("jirl br.target", br.target, a + {{14{o16[15]}}, o16, 2'b00});
        check("jirl alu_src1", ds_to_es.alu_src1, pc);
        check("jirl alu_src2", ds_to_es.alu_src2, 32'd4);
        check("jirl rf_waddr", 32'(ds_to_es.rf_waddr), 32'd20);
        o26 = 26'($urandom);
        issue(enc_i26(OP_BL, o26), pc);
        check("bl br.target", br.target, pc + {{4{o26[25]}}, o26, 2'b00});
        check("bl rf_we", 32'(ds_to_es.rf_we), 32'd1);
        check("bl rf_waddr", 32'(ds_to_es.rf_waddr), 32'd1);
        check("bl alu_src1", ds_to_es.alu_src1, pc);
        check("bl alu_src2", ds_to_es.alu_src2, 32'd4);
        // fetch offers the fall-through item while the branch leaves
        offer(enc_2ri16(OP_BEQ, 16'h0010, 5'd0, 5'd0), pc);
        @(negedge clk);
        fs_to_ds = '{enc_3r(FN_ADD_W, 5'd4, 5'd3, 5'd5), pc + 32'd4};
        #1;
        check("beq r0 br.taken", 32'(br.taken), 32'd1);
        @(negedge clk);
        fs_valid = 1'b0;
        #1;
        check("squashed ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
    endtask

    task automatic test_backpressure();
        ds_to_es_t held;
        @(negedge clk);
        es_allowin = 1'b0;
        issue(enc_3r(FN_XOR, 5'd4, 5'd3, 5'd9), rand_pc());
        held = ds_to_es;
        check("bp ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
        check("bp ds_allowin", 32'(ds_allowin), 32'd0);
        @(negedge clk);
        fs_valid = 1'b1;
        fs_to_ds = '{enc_3r(FN_OR, 5'd4, 5'd3, 5'd9), rand_pc()};
        for (int i = 0; i < 3; i++) begin
            #1;
            check("bp ds_to_es stable", 32'(ds_to_es == held), 32'd1);
            check("bp ds_allowin", 32'(ds_allowin), 32'd0);
            check("bp ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
            @(negedge clk);
        end
        fs_valid = 1'b0;
        es_allowin = 1'b1;
        #1;
        check("release ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
        check("release ds_to_es stable", 32'(ds_to_es == held), 32'd1);
        @(negedge clk);
        #1;
        check("left once ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
    endtask

    initial begin
        void'($urandom(32'h9ea9_7ff6));
        resetn     = 1'b0;
        fs_valid   = 1'b0;
        fs_to_ds   = '0;
        es_allowin = 1'b1;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_fwd     = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = 32'd0;
        end
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        #1;
        check("reset ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        check("reset br.taken", 32'(br.taken), 32'd0);
        check("reset ds_allowin", 32'(ds_allowin), 32'd1);

        test_alu_reg();
        test_imm_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_backpressure();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src.f
rtl/id_pkg.sv
rtl/regfile.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/id_control.sv
rtl/id_stage.sv
test/id_stage_assertions.sv
test/tb_id_stage.sv

//--- Makefile
# Verilator build of the decode stage testbench

OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_id_stage -Mdir $(OBJ_DIR) -o tb_id_stage
	./$(OBJ_DIR)/tb_id_stage

clean:
	rm -rf $(OBJ_DIR)
